// ==== tb/mem_cases.txt ====
# port (0 instr, 1 data)  op (0 read, 1 write, 2 random, 3 contend, 4 mtime step, 5 irq)
# address  write data (contend: data address, irq: mtimecmp_lo address)  expected, all hex
1 1 00000000 11111111 00000000
1 1 00000004 22222222 00000000
1 1 00000400 33333333 00000000
1 0 00000000 00000000 00000000
0 0 00000004 00000000 00000000
1 1 000003fc 44444444 00000000
0 0 000003fc 00000000 00000000
1 2 00000000 00000000 00000000
0 2 00000000 00000000 00000000
1 2 00000000 00000000 00000000
0 2 00000000 00000000 00000000
0 3 00000004 000003fc 00000000
1 1 40000014 0000002a 00000000
1 0 40000014 00000000 0000002a
1 1 4000000c 00000000 00000000
1 1 40000008 00100000 00000000
1 0 40000008 00000000 00100000
1 4 40000000 00000000 0000000a
1 5 40000000 40000008 00000003
1 1 40000018 00000001 00000000
1 0 00000004 00000000 00000000

// ==== soc_mem.f ====
hw/soc_mem_pkg.sv
hw/mem_cmd_arbiter.sv
hw/memory_map_controller.sv
hw/data_ram.sv
hw/timer_regs.sv
hw/soc_mem_top.sv
tb/tb_soc_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timescale 1ns/100ps --top-module tb_soc_mem -f soc_mem.f -o tb_soc_mem \
    && ./obj_dir/tb_soc_mem > sim.log 2>&1 \
    || echo "build or simulation returned an error"
grep -qs "Result: PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tb/tb_soc_mem.sv ====
`default_nettype none

module tb_soc_mem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FMAX_MHZ   = 4;
    localparam int RAM_WORDS  = 256;
    localparam int TIMEOUT    = 60;
    localparam int LATENCY    = 4;
    localparam int EXIT_WATCH = 20;

    logic        clkConstrained;
    logic        rst;
    logic        ireq_valid;
    logic [31:0] ireq_addr;
    logic        ireq_ready;
    logic        iresp_valid;
    logic [31:0] iresp_rdata;
    logic        dreq_valid;
    logic [31:0] dreq_addr;
    logic        dreq_wen;
    logic [31:0] dreq_wdata;
    logic        dreq_ready;
    logic        dresp_valid;
    logic [31:0] dresp_rdata;
    logic        timer_irq;
    logic [5:0]  led;
    logic        exited;

    // last value written to each ram word
    logic [31:0] model [RAM_WORDS];
    integer      seed = 70535;

    soc_mem_top #(
        .FMAX_MHZ  (FMAX_MHZ),
        .RAM_WORDS (RAM_WORDS)
    ) u_soc_mem_top (.*);

    initial begin
        clkConstrained = 1'b0;
        forever #20 clkConstrained = ~clkConstrained;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int tol);
        if ($isunknown(got) || (got > exp + tol) || (got + tol < exp)) begin
            fail_now($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // word index wrapped to the ram depth
    function automatic int ram_index(input logic [31:0] addr);
        return int'(addr[29:2]) % RAM_WORDS;
    endfunction

    // one request on one port while the other port stays idle
    task automatic access(input logic port, input logic wen, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clkConstrained);
        if (port) begin
            dreq_valid <= 1'b1;
            dreq_addr  <= addr;
            dreq_wen   <= wen;
            dreq_wdata <= wdata;
        end else begin
            ireq_valid <= 1'b1;
            ireq_addr  <= addr;
        end
        waited = 0;
        do begin
            @(negedge clkConstrained);
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("timeout waiting for request ready");
            end
        end while (!(port ? dreq_ready : ireq_ready));
        // transfer edge
        @(posedge clkConstrained);
        dreq_valid <= 1'b0;
        ireq_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clkConstrained);
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("timeout waiting for response valid");
            end
            check_val(port ? "iresp_valid" : "dresp_valid",
                      32'(port ? iresp_valid : dresp_valid), 32'd0, 0);
        end while (!(port ? dresp_valid : iresp_valid));
        check_val("response latency", 32'(waited), 32'(LATENCY), 0);
        rdata = port ? dresp_rdata : iresp_rdata;
    endtask

    // both ports start in the same cycle and data must come back first
    task automatic contend(input logic [31:0] iaddr, input logic [31:0] daddr);
        int   waited;
        logic d_seen;
        logic i_seen;
        logic d_go;
        logic i_go;
        @(posedge clkConstrained);
        ireq_valid <= 1'b1;
        ireq_addr  <= iaddr;
        dreq_valid <= 1'b1;
        dreq_addr  <= daddr;
        dreq_wen   <= 1'b0;
        dreq_wdata <= 32'd0;
        waited = 0;
        d_seen = 1'b0;
        i_seen = 1'b0;
        while (!(d_seen && i_seen)) begin
            @(negedge clkConstrained);
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("timeout waiting for both responses under contention");
            end
            if (dresp_valid) begin
                check_val("dresp_rdata", dresp_rdata, model[ram_index(daddr)], 0);
                d_seen = 1'b1;
            end
            if (iresp_valid) begin
                check_val("dresp_valid seen before iresp_valid", 32'(d_seen), 32'd1, 0);
                check_val("iresp_rdata", iresp_rdata, model[ram_index(iaddr)], 0);
                i_seen = 1'b1;
            end
            d_go = dreq_valid && dreq_ready;
            i_go = ireq_valid && ireq_ready;
            @(posedge clkConstrained);
            if (d_go) begin
                dreq_valid <= 1'b0;
            end
            if (i_go) begin
                ireq_valid <= 1'b0;
            end
        end
    endtask

    // fetch held up after exit so nothing may come back
    task automatic watch_fetch_stall(input logic [31:0] addr);
        @(posedge clkConstrained);
        ireq_valid <= 1'b1;
        ireq_addr  <= addr;
        repeat (EXIT_WATCH) begin
            @(negedge clkConstrained);
            check_val("ireq_ready", 32'(ireq_ready), 32'd0, 0);
            check_val("iresp_valid", 32'(iresp_valid), 32'd0, 0);
        end
        @(posedge clkConstrained);
        ireq_valid <= 1'b0;
    endtask

    initial begin
        int          fd;
        int          n_cases;
        int          waited;
        logic [31:0] port;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_col;
        logic [31:0] rdata;
        logic [31:0] first;
        string       header;
        rst        = 1'b1;
        ireq_valid = 1'b0;
        ireq_addr  = 32'd0;
        dreq_valid = 1'b0;
        dreq_addr  = 32'd0;
        dreq_wen   = 1'b0;
        dreq_wdata = 32'd0;
        n_cases    = 0;
        repeat (3) @(posedge clkConstrained);
        rst <= 1'b0;
        @(negedge clkConstrained);
        check_val("led", 32'(led), 32'h3f, 0);
        check_val("timer_irq", 32'(timer_irq), 32'd0, 0);
        check_val("exited", 32'(exited), 32'd0, 0);

        fd = $fopen("tb/mem_cases.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open tb/mem_cases.txt");
        end
        // two column description lines
        void'($fgets(header, fd));
        void'($fgets(header, fd));
        while ($fscanf(fd, "%h %h %h %h %h\n", port, op, addr, wdata, exp_col) == 5) begin
            n_cases++;
            case (op)
                0: begin
                    access(port[0], 1'b0, addr, 32'd0, rdata);
                    check_val(port[0] ? "dresp_rdata" : "iresp_rdata", rdata,
                              addr[30] ? exp_col : model[ram_index(addr)], 0);
                end
                1: begin
                    access(1'b1, 1'b1, addr, wdata, rdata);
                    check_val("dresp_rdata", rdata, exp_col, 0);
                    if (!addr[30]) begin
                        model[ram_index(addr)] = wdata;
                    end else if (addr[4:2] == 3'd5) begin
                        // leds are the inverted low gpio bits
                        check_val("led", 32'(led), {26'd0, ~wdata[5:0]}, 0);
                    end else if (addr[4:2] == 3'd6) begin
                        check_val("exited", 32'(exited), 32'd1, 0);
                        watch_fetch_stall(32'd0);
                    end
                end
                2: begin
                    addr  = 32'($random(seed)) & 32'hbfff_fffc;
                    wdata = 32'($random(seed));
                    access(1'b1, 1'b1, addr, wdata, rdata);
                    model[ram_index(addr)] = wdata;
                    access(port[0], 1'b0, addr, 32'd0, rdata);
                    check_val("random read data", rdata, wdata, 0);
                end
                3: contend(addr, wdata);
                4: begin
                    access(1'b1, 1'b0, addr, 32'd0, first);
                    // second transfer 40 cycles after the first
                    repeat (35) @(posedge clkConstrained);
                    access(1'b1, 1'b0, addr, 32'd0, rdata);
                    check_val("mtime delta", rdata - first, exp_col, 1);
                end
                5: begin
                    check_val("timer_irq", 32'(timer_irq), 32'd0, 0);
                    access(1'b1, 1'b0, addr, 32'd0, first);
                    access(1'b1, 1'b1, wdata, first + exp_col, rdata);
                    waited = 0;
                    while (!timer_irq) begin
                        @(negedge clkConstrained);
                        waited++;
                        if (waited > TIMEOUT) begin
                            fail_now("timeout waiting for timer_irq to rise");
                        end
                    end
                end
                default: fail_now($sformatf("unknown operation %0h in case file", op));
            endcase
        end
        if (!$feof(fd)) begin
            fail_now("case file has a line that cannot be read");
        end
        $fclose(fd);
        if (n_cases == 0) begin
            fail_now("case file holds no cases");
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/soc_mem_top.sv ====
`default_nettype none

module soc_mem_top #(
    parameter int FMAX_MHZ  = 27,
    parameter int RAM_WORDS = 1024
) (
    input  wire                           clkConstrained,
    input  wire                           rst,

    input  wire                           ireq_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]   ireq_addr,
    output logic                          ireq_ready,
    output logic                          iresp_valid,
    output logic [soc_mem_pkg::XLEN-1:0]  iresp_rdata,

    input  wire                           dreq_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]   dreq_addr,
    input  wire                           dreq_wen,
    input  wire [soc_mem_pkg::XLEN-1:0]   dreq_wdata,
    output logic                          dreq_ready,
    output logic                          dresp_valid,
    output logic [soc_mem_pkg::XLEN-1:0]  dresp_rdata,

    output logic                          timer_irq,
    output logic [soc_mem_pkg::LED_W-1:0] led,
    output logic                          exited
);

    localparam int RAM_AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    // arbiter to controller
    logic                               mem_req_valid;
    logic                               mem_req_ready;
    logic [soc_mem_pkg::XLEN-1:0]       mem_req_addr;
    logic                               mem_req_wen;
    logic [soc_mem_pkg::XLEN-1:0]       mem_req_wdata;
    logic                               mem_resp_valid;
    logic [soc_mem_pkg::XLEN-1:0]       mem_resp_rdata;

    // controller to ram
    logic                               ram_en;
    logic                               ram_we;
    logic [RAM_AW-1:0]                  ram_addr;
    logic [soc_mem_pkg::XLEN-1:0]       ram_wdata;
    logic [soc_mem_pkg::XLEN-1:0]       ram_rdata;

    // controller to registers
    logic                               reg_wr;
    logic [soc_mem_pkg::REG_SEL_W-1:0]  reg_sel;
    logic [soc_mem_pkg::XLEN-1:0]       reg_wdata;
    logic [soc_mem_pkg::XLEN-1:0]       reg_rdata;

    mem_cmd_arbiter u_mem_cmd_arbiter (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .exited         (exited),
        .ireq_valid     (ireq_valid),
        .ireq_addr      (ireq_addr),
        .ireq_ready     (ireq_ready),
        .iresp_valid    (iresp_valid),
        .iresp_rdata    (iresp_rdata),
        .dreq_valid     (dreq_valid),
        .dreq_addr      (dreq_addr),
        .dreq_wen       (dreq_wen),
        .dreq_wdata     (dreq_wdata),
        .dreq_ready     (dreq_ready),
        .dresp_valid    (dresp_valid),
        .dresp_rdata    (dresp_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    memory_map_controller #(
        .RAM_WORDS (RAM_WORDS)
    ) u_memory_map_controller (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .mem_req_ready  (mem_req_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .reg_wr         (reg_wr),
        .reg_sel        (reg_sel),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .exited         (exited)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clkConstrained (clkConstrained),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata)
    );

    timer_regs #(
        .FMAX_MHZ (FMAX_MHZ)
    ) u_timer_regs (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .reg_wr         (reg_wr),
        .reg_sel        (reg_sel),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .timer_irq      (timer_irq),
        .led            (led)
    );

endmodule

`default_nettype wire

// ==== hw/timer_regs.sv ====
`default_nettype none

module timer_regs #(
    parameter int FMAX_MHZ = 27
) (
    input  wire                                 clkConstrained,
    input  wire                                 rst,
    input  wire                                 reg_wr,
    input  wire [soc_mem_pkg::REG_SEL_W-1:0]    reg_sel,
    input  wire [soc_mem_pkg::XLEN-1:0]         reg_wdata,
    output logic [soc_mem_pkg::XLEN-1:0]        reg_rdata,
    output logic                                timer_irq,
    output logic [soc_mem_pkg::LED_W-1:0]       led
);

    localparam int PRE_W = (FMAX_MHZ > 1) ? $clog2(FMAX_MHZ) : 1;

    logic [PRE_W-1:0]              prescale_q;
    logic [63:0]                   mtime_q;
    logic [63:0]                   mtimecmp_q;
    logic [63:0]                   cycle_q;
    logic [soc_mem_pkg::XLEN-1:0]  gpio_q;
    logic                          tick;

    // one tick per microsecond
    assign tick = (prescale_q == PRE_W'(FMAX_MHZ - 1));

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            prescale_q <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            cycle_q    <= '0;
            gpio_q     <= '0;
            timer_irq  <= 1'b0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            if (tick) begin
                prescale_q <= '0;
                mtime_q    <= mtime_q + 64'd1;
            end else begin
                prescale_q <= prescale_q + PRE_W'(1);
            end
            timer_irq <= (mtime_q >= mtimecmp_q);
            // only mtimecmp and gpio are writable here
            if (reg_wr) begin
                case (reg_sel)
                    soc_mem_pkg::REG_MTIMECMP_LO: mtimecmp_q[31:0]  <= reg_wdata;
                    soc_mem_pkg::REG_MTIMECMP_HI: mtimecmp_q[63:32] <= reg_wdata;
                    soc_mem_pkg::REG_GPIO:        gpio_q            <= reg_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            soc_mem_pkg::REG_MTIME_LO:    reg_rdata = mtime_q[31:0];
            soc_mem_pkg::REG_MTIME_HI:    reg_rdata = mtime_q[63:32];
            soc_mem_pkg::REG_MTIMECMP_LO: reg_rdata = mtimecmp_q[31:0];
            soc_mem_pkg::REG_MTIMECMP_HI: reg_rdata = mtimecmp_q[63:32];
            soc_mem_pkg::REG_CYCLE_LO:    reg_rdata = cycle_q[31:0];
            soc_mem_pkg::REG_GPIO:        reg_rdata = gpio_q;
            default:                      reg_rdata = '0;
        endcase
    end

    // leds are active low on the board
    assign led = ~gpio_q[soc_mem_pkg::LED_W-1:0];

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
`default_nettype none

module data_ram #(
    parameter  int RAM_WORDS = 1024,
    localparam int RAM_AW    = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1
) (
    input  wire                           clkConstrained,
    input  wire                           ram_en,
    input  wire                           ram_we,
    input  wire [RAM_AW-1:0]              ram_addr,
    input  wire [soc_mem_pkg::XLEN-1:0]   ram_wdata,
    output logic [soc_mem_pkg::XLEN-1:0]  ram_rdata
);

    logic [soc_mem_pkg::XLEN-1:0] mem [RAM_WORDS];

    // a write returns the word it replaces
    always_ff @(posedge clkConstrained) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/memory_map_controller.sv ====
`default_nettype none

module memory_map_controller #(
    parameter  int RAM_WORDS = 1024,
    localparam int RAM_AW    = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1
) (
    input  wire                                clkConstrained,
    input  wire                                rst,

    // command side
    output logic                               mem_req_ready,
    input  wire                                mem_req_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]        mem_req_addr,
    input  wire                                mem_req_wen,
    input  wire [soc_mem_pkg::XLEN-1:0]        mem_req_wdata,
    output logic                               mem_resp_valid,
    output logic [soc_mem_pkg::XLEN-1:0]       mem_resp_rdata,

    // word ram
    output logic                               ram_en,
    output logic                               ram_we,
    output logic [RAM_AW-1:0]                  ram_addr,
    output logic [soc_mem_pkg::XLEN-1:0]       ram_wdata,
    input  wire [soc_mem_pkg::XLEN-1:0]        ram_rdata,

    // register block
    output logic                               reg_wr,
    output logic [soc_mem_pkg::REG_SEL_W-1:0]  reg_sel,
    output logic [soc_mem_pkg::XLEN-1:0]       reg_wdata,
    input  wire [soc_mem_pkg::XLEN-1:0]        reg_rdata,

    output logic                               exited
);

    soc_mem_pkg::mem_addr_t          req_addr_q;
    logic                            req_wen_q;
    logic [soc_mem_pkg::XLEN-1:0]    req_wdata_q;
    logic                            stage1_q;
    logic                            stage2_q;
    logic                            resp_valid_q;
    logic [soc_mem_pkg::XLEN-1:0]    reg_rdata_q;
    logic [soc_mem_pkg::XLEN-1:0]    resp_rdata_q;
    logic                            accept;
    logic                            is_mmio;

    // busy from accept until the response pulse has gone out
    assign mem_req_ready = !(stage1_q || stage2_q || resp_valid_q);
    assign accept        = mem_req_valid && mem_req_ready;
    assign is_mmio       = req_addr_q.mmio.region;

    // stage 1 drives ram or registers from the captured request
    assign ram_en    = stage1_q && !is_mmio;
    assign ram_we    = ram_en && req_wen_q;
    // ram wraps around its own depth
    assign ram_addr  = RAM_AW'(req_addr_q.ram.word_idx % RAM_WORDS);
    assign ram_wdata = req_wdata_q;

    assign reg_wr    = stage1_q && is_mmio && req_wen_q;
    assign reg_sel   = req_addr_q.mmio.reg_sel;
    assign reg_wdata = req_wdata_q;

    assign mem_resp_valid = resp_valid_q;
    assign mem_resp_rdata = resp_rdata_q;

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            stage1_q     <= 1'b0;
            stage2_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            exited       <= 1'b0;
        end else begin
            stage1_q     <= accept;
            stage2_q     <= stage1_q;
            resp_valid_q <= stage2_q;
            // sticky until reset
            if (reg_wr && (reg_sel == soc_mem_pkg::REG_EXIT)) begin
                exited <= 1'b1;
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (accept) begin
            req_addr_q  <= mem_req_addr;
            req_wen_q   <= mem_req_wen;
            req_wdata_q <= mem_req_wdata;
        end
        // register read value taken in stage 1 like the ram read
        if (stage1_q && is_mmio) begin
            reg_rdata_q <= reg_rdata;
        end
        // writes answer with zero
        if (stage2_q) begin
            if (req_wen_q) begin
                resp_rdata_q <= '0;
            end else if (is_mmio) begin
                resp_rdata_q <= reg_rdata_q;
            end else begin
                resp_rdata_q <= ram_rdata;
            end
        end
    end

    // every accept gets its pulse three cycles on with no accept in between
    a_accept_to_resp: assert property (
        @(posedge clkConstrained) disable iff (rst)
        accept |=> !accept ##1 !accept ##1 (mem_resp_valid && !accept)
    );

endmodule

`default_nettype wire

// ==== hw/mem_cmd_arbiter.sv ====
`default_nettype none

module mem_cmd_arbiter (
    input  wire                           clkConstrained,
    input  wire                           rst,
    input  wire                           exited,

    // instruction fetch port, read only
    input  wire                           ireq_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]   ireq_addr,
    output logic                          ireq_ready,
    output logic                          iresp_valid,
    output logic [soc_mem_pkg::XLEN-1:0]  iresp_rdata,

    // data access port
    input  wire                           dreq_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]   dreq_addr,
    input  wire                           dreq_wen,
    input  wire [soc_mem_pkg::XLEN-1:0]   dreq_wdata,
    output logic                          dreq_ready,
    output logic                          dresp_valid,
    output logic [soc_mem_pkg::XLEN-1:0]  dresp_rdata,

    // towards the memory map controller
    output logic                          mem_req_valid,
    output logic [soc_mem_pkg::XLEN-1:0]  mem_req_addr,
    output logic                          mem_req_wen,
    output logic [soc_mem_pkg::XLEN-1:0]  mem_req_wdata,
    input  wire                           mem_req_ready,
    input  wire                           mem_resp_valid,
    input  wire [soc_mem_pkg::XLEN-1:0]   mem_resp_rdata
);

    logic                   busy_q;
    soc_mem_pkg::resp_src_e src_q;
    logic                   itake;
    logic                   dtake;

    // one slot only and the data port goes first
    assign dreq_ready = !busy_q;
    // fetches stop for good once the program has exited
    assign ireq_ready = !busy_q && !exited && !dreq_valid;

    assign dtake = dreq_valid && dreq_ready;
    assign itake = ireq_valid && ireq_ready;

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            busy_q        <= 1'b0;
            mem_req_valid <= 1'b0;
            src_q         <= soc_mem_pkg::SRC_INSTR;
        end else if (dtake || itake) begin
            busy_q        <= 1'b1;
            mem_req_valid <= 1'b1;
            src_q         <= dtake ? soc_mem_pkg::SRC_DATA : soc_mem_pkg::SRC_INSTR;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            // slot frees on the response pulse
            if (mem_resp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (dtake) begin
            mem_req_addr  <= dreq_addr;
            mem_req_wen   <= dreq_wen;
            mem_req_wdata <= dreq_wdata;
        end else if (itake) begin
            mem_req_addr  <= ireq_addr;
            mem_req_wen   <= 1'b0;
            mem_req_wdata <= '0;
        end
    end

    // response goes back to whoever issued the request
    assign iresp_valid = mem_resp_valid && (src_q == soc_mem_pkg::SRC_INSTR);
    assign dresp_valid = mem_resp_valid && (src_q == soc_mem_pkg::SRC_DATA);
    assign iresp_rdata = mem_resp_rdata;
    assign dresp_rdata = mem_resp_rdata;

    // a controller response always lands on exactly one user port
    a_resp_one_port: assert property (
        @(posedge clkConstrained) disable iff (rst)
        mem_resp_valid |-> busy_q && (iresp_valid ^ dresp_valid)
    );

    // request held steady until the controller takes it
    a_req_hold: assert property (
        @(posedge clkConstrained) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=>
            mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_wen)
            && $stable(mem_req_wdata)
    );

endmodule

`default_nettype wire

// ==== hw/soc_mem_pkg.sv ====
`default_nettype none

package soc_mem_pkg;

    // data and address word width
    localparam int XLEN = 32;

    // register block base; the single set bit picks mmio over ram
    localparam logic [XLEN-1:0] MMIO_BASE = 32'h4000_0000;
    localparam int REGION_BIT = $clog2(MMIO_BASE);

    // address field widths
    localparam int BYTE_OFF_W = 2;
    localparam int REG_SEL_W  = 3;
    localparam int SPARE_W    = XLEN - REGION_BIT - 1;
    localparam int WORD_IDX_W = REGION_BIT - BYTE_OFF_W;
    localparam int MMIO_PAD_W = REGION_BIT - REG_SEL_W - BYTE_OFF_W;

    // gpio bits that reach the board
    localparam int LED_W = 6;

    // register word offsets inside the mmio block
    localparam logic [REG_SEL_W-1:0] REG_MTIME_LO    = 3'd0;
    localparam logic [REG_SEL_W-1:0] REG_MTIME_HI    = 3'd1;
    localparam logic [REG_SEL_W-1:0] REG_MTIMECMP_LO = 3'd2;
    localparam logic [REG_SEL_W-1:0] REG_MTIMECMP_HI = 3'd3;
    localparam logic [REG_SEL_W-1:0] REG_CYCLE_LO    = 3'd4;
    localparam logic [REG_SEL_W-1:0] REG_GPIO        = 3'd5;
    // any write to tohost ends the run
    localparam logic [REG_SEL_W-1:0] REG_EXIT        = 3'd6;

    // one address word, seen as a ram word index or a register select
    typedef union packed {
        struct packed {
            logic [SPARE_W-1:0]    spare;
            logic                  region;
            logic [WORD_IDX_W-1:0] word_idx;
            logic [BYTE_OFF_W-1:0] byte_off;
        } ram;
        struct packed {
            logic [SPARE_W-1:0]    spare;
            logic                  region;
            logic [MMIO_PAD_W-1:0] pad;
            logic [REG_SEL_W-1:0]  reg_sel;
            logic [BYTE_OFF_W-1:0] byte_off;
        } mmio;
    } mem_addr_t;

    // which port owns the outstanding request
    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } resp_src_e;

endpackage

`default_nettype wire
